/* compile.f */
+incdir+logic
logic/msxBusPkg.sv
logic/expansionBus.sv
logic/cartControl.sv
logic/sramBank.sv
logic/ioTimerBlock.sv
logic/msxCartTop.sv
verification/msxCartChecker.sv
verification/msxCartTb.sv

/* run.sh */
#!/bin/sh
# Build the cartridge testbench with Verilator, run it and scan the log

verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module msxCartTb \
        -o msxCartSim \
    && ./obj_dir/msxCartSim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "STATUS: FAIL" sim.log \
    || { echo "Build or simulation failed, see sim.log"; exit 1; }

/* verification/msxCartTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cartridge_macros.svh"

module msxCartTb;
    import msxBusPkg::*;

    typedef enum logic [2:0] {memWrite, memRead, ioWrite, ioRead, waitInt, busReset} op_t;

    localparam int          WAIT_LIMIT  = 20;  // Cycles allowed with wait_n low
    localparam int          INT_LIMIT   = 3 * `TIMER_PRESCALE + 20;
    localparam logic [15:0] IO_PORT     = {8'h00, `IO_BASE};
    localparam int          CHK_SAMPLE  = 0;
    localparam int          CHK_DONE    = 1;
    localparam int          CHK_IDLE    = 2;
    localparam int          CHK_TIMEOUT = 3;

    logic        CLK;
    logic        RESET_n;
    msxReq_t     busIn;
    msxResp_t    busOut;
    msxReq_t     extReq;
    msxResp_t    extResp;
    logic        extEnable;  // External cartridge answers its page
    logic        hung;
    logic [95:0] testName;
    logic [8:0]  expected;   // {busdir_n, dout}
    logic        sample;
    logic        idleCheck;
    logic        done;
    logic        timedOut;
    int          passCount;
    int          failCount;
    logic [7:0]  pattern [4];

    // Stimulus table, one queue per column
    logic [95:0] names   [$];
    op_t         ops     [$];
    logic [15:0] addrs   [$];
    logic [7:0]  datas   [$];
    logic [8:0]  expects [$];

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    msxCartTop msxCartTop_inst (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .busIn   (busIn),
        .busOut  (busOut),
        .extReq  (extReq),
        .extResp (extResp)
    );

    msxCartChecker msxCartChecker_inst (
        .CLK       (CLK),
        .busOut    (busOut),
        .extReq    (extReq),
        .testName  (testName),
        .expected  (expected),
        .sample    (sample),
        .idleCheck (idleCheck),
        .done      (done),
        .timedOut  (timedOut),
        .passCount (passCount),
        .failCount (failCount)
    );

    // Secondary 1 cartridge, readable in page 8000h-BFFFh
    always_comb begin
        extResp = '{dout: 8'h00, busdir_n: 1'b1, int_n: 1'b1, wait_n: 1'b1};
        if (extEnable && !extReq.sltsl_n && !extReq.merq_n && !extReq.rd_n
                && extReq.addr[15:14] == 2'b10) begin
            extResp.dout     = extReq.addr[7:0] ^ 8'hA5;
            extResp.busdir_n = 1'b0;
        end
    end

    task automatic addEntry(input logic [95:0] name, input op_t op, input logic [15:0] addr,
                            input logic [7:0] data, input logic [8:0] exp);
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(addr);
        datas.push_back(data);
        expects.push_back(exp);
    endtask

    task automatic notifyChecker(input int kind);
        sample    = (kind == CHK_SAMPLE);
        done      = (kind == CHK_DONE);
        idleCheck = (kind == CHK_IDLE);
        timedOut  = (kind == CHK_TIMEOUT);
        @(negedge CLK);
        {sample, done, idleCheck, timedOut} = 4'b0000;
    endtask

    task automatic releaseBus();
        busIn.rd_n    = 1'b1;
        busIn.wr_n    = 1'b1;
        busIn.merq_n  = 1'b1;
        busIn.iorq_n  = 1'b1;
        busIn.sltsl_n = 1'b1;
    endtask

    // One MSX bus cycle, the strobe is held until wait_n is high
    task automatic busCycle(input logic isMem, input logic isRead, input logic [15:0] addr,
                            input logic [7:0] data, input int kind);
        int t;
        busIn.addr    = addr;
        busIn.din     = data;
        busIn.sltsl_n = !isMem;
        busIn.merq_n  = !isMem;
        busIn.iorq_n  = isMem;
        busIn.rd_n    = !isRead;
        busIn.wr_n    = isRead;
        repeat (4) @(negedge CLK);
        t = 0;
        while (!busOut.wait_n && t < WAIT_LIMIT) begin
            @(negedge CLK);
            t++;
        end
        if (!busOut.wait_n) begin
            hung = 1'b1;
            notifyChecker(CHK_TIMEOUT);
        end else begin
            notifyChecker(kind);  // Strobe still low here
        end
        releaseBus();
        repeat (2) @(negedge CLK);
    endtask

    initial begin
        int t;
        void'($urandom(50852));
        RESET_n = 1'b0;
        busIn = '{addr: 16'h0000, din: 8'h00, rd_n: 1'b1, wr_n: 1'b1, merq_n: 1'b1,
                  iorq_n: 1'b1, sltsl_n: 1'b1, rfsh_n: 1'b1, m1_n: 1'b1, cs1_n: 1'b1,
                  cs2_n: 1'b1, cs12_n: 1'b1, busReset_n: 1'b1};
        {sample, done, idleCheck, timedOut} = 4'b0000;
        extEnable = 1'b0;
        hung      = 1'b0;
        testName  = '0;
        expected  = '0;

        for (int i = 0; i < 4; i++) begin
            pattern[i] = 8'($urandom);
            addEntry(96'({"sramWr", 8'(8'h30 + i)}), memWrite, 16'h4000 + 16'(i), pattern[i],
                     9'h000);
        end
        for (int i = 0; i < 4; i++) begin
            addEntry(96'({"sramRd", 8'(8'h30 + i)}), memRead, 16'h4000 + 16'(i), 8'h00,
                     {1'b0, pattern[i]});
        end
        addEntry("sramMirror", memRead, 16'h4400, 8'h00, {1'b0, pattern[0]});  // 1 KiB wraps
        for (int i = 0; i < 4; i++) begin
            addEntry(96'({"ioWr", 8'(8'h30 + i)}), ioWrite, IO_PORT + 16'(i),
                     8'(8'h11 * (i + 1)), 9'h000);
        end
        for (int i = 0; i < 4; i++) begin
            addEntry(96'({"ioRd", 8'(8'h30 + i)}), ioRead, IO_PORT + 16'(i), 8'h00,
                     {1'b0, 8'(8'h11 * (i + 1))});
        end
        addEntry("unmappedIo", ioRead, 16'h0050, 8'h00, 9'h100);
        // Data column of a memory read turns the external cartridge on
        addEntry("extRead", memRead, 16'h8123, 8'h01, {1'b0, 8'h23 ^ 8'hA5});
        addEntry("extNoAnswer", memRead, 16'h8000, 8'h00, 9'h100);
        addEntry("timerLoad", ioWrite, IO_PORT + 16'd4, 8'd3, 9'h000);
        addEntry("intRaised", waitInt, 16'h0000, 8'h00, 9'h000);  // Wait for int_n low
        addEntry("intStatus", ioRead, IO_PORT + 16'd5, 8'h00, 9'h001);
        addEntry("intCleared", waitInt, 16'h0000, 8'h01, 9'h000);
        addEntry("intStatus2", ioRead, IO_PORT + 16'd5, 8'h00, 9'h000);
        addEntry("busResetWr", busReset, 16'h4000, ~pattern[0], 9'h000);
        addEntry("afterReset", memRead, 16'h4000, 8'h00, {1'b0, pattern[0]});

        repeat (10) @(negedge CLK);
        RESET_n = 1'b1;
        repeat (2) @(negedge CLK);

        for (int i = 0; i < names.size() && !hung; i++) begin
            testName = names[i];
            expected = expects[i];
            case (ops[i])
                memWrite: busCycle(1'b1, 1'b0, addrs[i], datas[i], CHK_DONE);
                memRead: begin
                    extEnable = datas[i][0];
                    busCycle(1'b1, 1'b1, addrs[i], 8'h00, CHK_SAMPLE);
                end
                ioWrite:  busCycle(1'b0, 1'b0, addrs[i], datas[i], CHK_DONE);
                ioRead:   busCycle(1'b0, 1'b1, addrs[i], 8'h00, CHK_SAMPLE);
                waitInt: begin
                    t = 0;
                    while (busOut.int_n !== datas[i][0] && t < INT_LIMIT) begin
                        @(negedge CLK);
                        t++;
                    end
                    if (busOut.int_n === datas[i][0]) begin
                        notifyChecker(CHK_DONE);
                    end else begin
                        hung = 1'b1;
                        notifyChecker(CHK_TIMEOUT);
                    end
                end
                busReset: begin
                    busIn.busReset_n = 1'b0;
                    repeat (2) @(negedge CLK);
                    busCycle(1'b1, 1'b0, addrs[i], datas[i], CHK_IDLE);  // Must be ignored
                    busIn.busReset_n = 1'b1;
                    repeat (2) @(negedge CLK);
                end
                default: ;
            endcase
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && !hung) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/msxCartChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module msxCartChecker (
    input  wire                      CLK,
    input  wire msxBusPkg::msxResp_t busOut,
    input  wire msxBusPkg::msxReq_t  extReq,
    input  wire [95:0]               testName,
    input  wire [8:0]                expected,   // {busdir_n, dout}
    input  wire                      sample,     // Compare read data now
    input  wire                      idleCheck,  // Bus and slot 1 must look idle
    input  wire                      done,       // Finished, nothing to compare
    input  wire                      timedOut,
    output int                       passCount,
    output int                       failCount
);
    // Slot 1 request while the MSX bus is in reset
    // addr and din zero, strobes and selects high, busReset_n low
    localparam logic [34:0] QUIET_REQ = {16'h0000, 8'h00, 10'h3ff, 1'b0};

    logic [8:0] readValue;

    assign readValue = {busOut.busdir_n, busOut.dout};

    initial begin
        passCount = 0;
        failCount = 0;
    end

    // Values seen here are the ones present at the preceding falling edge
    always @(posedge CLK) begin
        if (sample) begin
            if (readValue === expected) begin
                $display("%s: ok, read %h", testName, readValue);
                passCount++;
            end else begin
                $display("Mismatch in %s: expected %h, actual %h", testName, expected, readValue);
                failCount++;
            end
        end
        if (idleCheck) begin
            if (busOut !== 11'h007) begin  // dout 00h, busdir_n, int_n, wait_n high
                $display("Mismatch in %s: expected response %h, actual %h",
                         testName, 11'h007, busOut);
                failCount++;
            end else if (extReq !== QUIET_REQ) begin
                $display("Mismatch in %s: expected slot 1 request %h, actual %h",
                         testName, QUIET_REQ, extReq);
                failCount++;
            end else begin
                $display("%s: ok, bus idle", testName);
                passCount++;
            end
        end
        if (done) begin
            $display("%s: ok", testName);
            passCount++;
        end
        if (timedOut) begin
            $display("%s: timed out waiting for the DUT", testName);
            failCount++;
        end
    end

endmodule

`default_nettype wire

/* logic/msxCartTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cartridge_macros.svh"

module msxCartTop (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire msxBusPkg::msxReq_t  busIn,
    output msxBusPkg::msxResp_t      busOut,
    output msxBusPkg::msxReq_t       extReq,
    input  wire msxBusPkg::msxResp_t extResp
);
    import msxBusPkg::*;

    msxReq_t    secReq  [`SLOT_COUNT];
    msxResp_t   secResp [`SLOT_COUNT];
    logic       memReq;
    memCmd_t    memCmd;
    logic       memAck;
    logic [7:0] memRdData;
    ioCmd_t     ioCmd;
    logic [7:0] ioRdData;
    logic       intPending;

    // Secondary 1 goes out to the external cartridge
    assign extReq     = secReq[1];
    assign secResp[1] = extResp;

    // Unused secondaries stay off the bus
    for (genvar i = 2; i < `SLOT_COUNT; i++) begin : idleSlot
        assign secResp[i] = RESP_IDLE;
    end

    expansionBus #(
        .COUNT(`SLOT_COUNT)
    ) expansionBus_inst (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .priReq  (busIn),
        .priResp (busOut),
        .secReq  (secReq),
        .secResp (secResp)
    );

    cartControl cartControl_inst (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .req        (secReq[0]),  // Internal cartridge
        .resp       (secResp[0]),
        .memReq     (memReq),
        .memCmd     (memCmd),
        .memAck     (memAck),
        .memRdData  (memRdData),
        .ioCmd      (ioCmd),
        .ioRdData   (ioRdData),
        .intPending (intPending)
    );

    sramBank sramBank_inst (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .memReq  (memReq),
        .memCmd  (memCmd),
        .memAck  (memAck),
        .rdData  (memRdData)
    );

    ioTimerBlock ioTimerBlock_inst (
        .CLK        (CLK),
        .RESET_n    (RESET_n),
        .ioCmd      (ioCmd),
        .rdData     (ioRdData),
        .intPending (intPending)
    );

endmodule

`default_nettype wire

/* logic/ioTimerBlock.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cartridge_macros.svh"

module ioTimerBlock (
    input  wire                    CLK,
    input  wire                    RESET_n,
    input  wire msxBusPkg::ioCmd_t ioCmd,
    output logic [7:0]             rdData,
    output logic                   intPending
);
    localparam int PRESCALE_BITS = $clog2(`TIMER_PRESCALE);

    logic [7:0]               scratch [4];
    logic [7:0]               count;     // Ticks left, zero means stopped
    logic [PRESCALE_BITS-1:0] prescale;
    logic                     tick;
    logic                     load;

    assign load = ioCmd.wr && (ioCmd.port == 3'd4);
    assign tick = (count != 8'd0) && (prescale == PRESCALE_BITS'(`TIMER_PRESCALE - 1));

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            count      <= 8'd0;
            prescale   <= '0;
            intPending <= 1'b0;
        end else begin
            if (load) begin
                count    <= ioCmd.wrData;
                prescale <= '0;
            end else if (count != 8'd0) begin
                prescale <= tick ? '0 : prescale + 1'b1;
                if (tick) begin
                    count <= count - 8'd1;
                end
            end

            // Status read acknowledges the interrupt
            if (ioCmd.rd && (ioCmd.port == 3'd5)) begin
                intPending <= 1'b0;
            end
            if (!load && tick && (count == 8'd1)) begin
                intPending <= 1'b1;  // Expiry wins over a same-cycle clear
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (ioCmd.wr && !ioCmd.port[2]) begin
            scratch[ioCmd.port[1:0]] <= ioCmd.wrData;
        end
    end

    // Combinational so data is valid in the rd strobe cycle
    always_comb begin
        case (ioCmd.port)
            3'd0, 3'd1, 3'd2, 3'd3: rdData = scratch[ioCmd.port[1:0]];
            3'd4:                   rdData = count;
            3'd5:                   rdData = {7'd0, intPending};
            default:                rdData = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* logic/sramBank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cartridge_macros.svh"

module sramBank (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     memReq,
    input  wire msxBusPkg::memCmd_t memCmd,
    output logic                    memAck,
    output logic [7:0]              rdData
);
    localparam int DEPTH = 1 << `SRAM_ADDR_BITS;

    logic [7:0] mem [DEPTH];
    logic       accessStage;  // First stage, array access in flight
    logic       accept;

    // Take a request only while the previous handshake is closed
    assign accept = memReq && !memAck && !accessStage;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            accessStage <= 1'b0;
            memAck      <= 1'b0;
        end else begin
            accessStage <= accept;
            // Ack stays up until the requester drops req
            memAck      <= accessStage || (memAck && memReq);
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            if (memCmd.write) begin
                mem[memCmd.addr] <= memCmd.wrData;
            end else begin
                rdData <= mem[memCmd.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/cartControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cartridge_macros.svh"

module cartControl (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire msxBusPkg::msxReq_t  req,
    output msxBusPkg::msxResp_t      resp,
    output logic                     memReq,
    output msxBusPkg::memCmd_t       memCmd,
    input  wire                      memAck,
    input  wire [7:0]                memRdData,
    output msxBusPkg::ioCmd_t        ioCmd,
    input  wire [7:0]                ioRdData,
    input  wire                      intPending
);
    import msxBusPkg::*;

    typedef enum logic [1:0] {
        stateIdle,
        stateMem,     // Waiting for the SRAM ack
        stateHold     // Driving the bus until the strobe rises
    } state_t;

    state_t     state;
    logic       strobeLow;
    logic       strobePrev;
    logic       cycleStart;
    logic       memHit;
    logic       ioHit;
    logic [7:0] ioOffset;

    assign strobeLow  = !req.rd_n || !req.wr_n;
    assign cycleStart = strobeLow && !strobePrev && req.busReset_n;  // New strobe only

    // Page 1 of our slot, refresh cycles excluded
    assign memHit = !req.sltsl_n && !req.merq_n && req.rfsh_n && (req.addr[15:14] == 2'b01);

    assign ioOffset = req.addr[7:0] - `IO_BASE;
    assign ioHit    = !req.iorq_n && (req.addr[7:0] >= `IO_BASE) && (ioOffset < 8'd6);

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state      <= stateIdle;
            strobePrev <= 1'b0;
            memReq     <= 1'b0;
            ioCmd      <= '0;
            resp       <= RESP_IDLE;
        end else begin
            strobePrev <= strobeLow;
            ioCmd.rd   <= 1'b0;
            ioCmd.wr   <= 1'b0;
            resp.int_n <= !intPending;

            case (state)
                stateIdle: begin
                    if (cycleStart && memHit) begin
                        memReq      <= 1'b1;
                        resp.wait_n <= 1'b0;  // Stretch the cycle until ack
                        state       <= stateMem;
                    end else if (cycleStart && ioHit) begin
                        ioCmd.port   <= ioOffset[2:0];
                        ioCmd.wrData <= req.din;
                        ioCmd.rd     <= !req.rd_n;
                        ioCmd.wr     <= !req.wr_n;
                        state        <= stateHold;
                    end
                end

                stateMem: begin
                    if (memAck) begin
                        memReq      <= 1'b0;
                        resp.wait_n <= 1'b1;
                        if (!memCmd.write) begin
                            resp.dout     <= memRdData;
                            resp.busdir_n <= 1'b0;
                        end
                        state <= stateHold;
                    end
                end

                stateHold: begin
                    // I/O read data is valid while the rd strobe is high
                    if (ioCmd.rd) begin
                        resp.dout     <= ioRdData;
                        resp.busdir_n <= 1'b0;
                    end
                    if (!strobeLow) begin
                        resp.dout     <= 8'h00;
                        resp.busdir_n <= 1'b1;
                        if (!memAck) begin
                            state <= stateIdle;  // Handshake fully closed
                        end
                    end
                end

                default: state <= stateIdle;
            endcase
        end
    end

    // SRAM command, held stable for the whole handshake
    always_ff @(posedge CLK) begin
        if (state == stateIdle && cycleStart && memHit) begin
            memCmd.addr   <= req.addr[`SRAM_ADDR_BITS-1:0];  // Mirrors over the page
            memCmd.wrData <= req.din;
            memCmd.write  <= !req.wr_n;
        end
    end

endmodule

`default_nettype wire

/* logic/expansionBus.sv */
`timescale 1ns/1ps
`default_nettype none

module expansionBus #(
    parameter int COUNT = 2
) (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire msxBusPkg::msxReq_t  priReq,
    output msxBusPkg::msxResp_t      priResp,
    output msxBusPkg::msxReq_t       secReq  [COUNT],
    input  wire msxBusPkg::msxResp_t secResp [COUNT]
);
    import msxBusPkg::*;

    // Merge chain, element COUNT is the idle terminator
    msxResp_t chain [COUNT+1];

    // Data ORed, active-low lines ANDed
    function automatic msxResp_t mergeResp(input msxResp_t a, input msxResp_t b);
        msxResp_t m;
        m.dout     = a.dout | b.dout;
        m.busdir_n = a.busdir_n & b.busdir_n;
        m.int_n    = a.int_n & b.int_n;
        m.wait_n   = a.wait_n & b.wait_n;
        return m;
    endfunction

    // Request fan-out, one register stage per secondary
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < COUNT; i++) begin
                secReq[i] <= REQ_IDLE;
            end
        end else begin
            for (int i = 0; i < COUNT; i++) begin
                if (!priReq.busReset_n) begin
                    secReq[i] <= REQ_IDLE;  // Secondaries see bus reset low
                end else begin
                    secReq[i] <= priReq;
                end
            end
        end
    end

    assign chain[COUNT] = RESP_IDLE;

    for (genvar i = 0; i < COUNT; i++) begin : merge
        assign chain[i] = mergeResp(secResp[i], chain[i+1]);
    end

    // Registered response back to the primary slot
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            priResp <= RESP_IDLE;
        end else if (!priReq.busReset_n) begin
            priResp <= RESP_IDLE;
        end else begin
            priResp <= chain[0];
        end
    end

endmodule

`default_nettype wire

/* logic/msxBusPkg.sv */
`default_nettype none

`include "cartridge_macros.svh"

package msxBusPkg;

    // MSX to cartridge
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  din;
        logic        rd_n;
        logic        wr_n;
        logic        merq_n;
        logic        iorq_n;
        logic        sltsl_n;
        logic        rfsh_n;
        logic        m1_n;
        logic        cs1_n;
        logic        cs2_n;
        logic        cs12_n;
        logic        busReset_n;  // MSX side reset, not the local one
    } msxReq_t;

    // Cartridge to MSX
    typedef struct packed {
        logic [7:0] dout;         // 00h when not driving
        logic       busdir_n;     // Low while dout is valid
        logic       int_n;
        logic       wait_n;
    } msxResp_t;

    typedef struct packed {
        logic [`SRAM_ADDR_BITS-1:0] addr;
        logic [7:0]                 wrData;
        logic                       write;
    } memCmd_t;

    typedef struct packed {
        logic [2:0] port;         // Offset from the I/O base
        logic [7:0] wrData;
        logic       rd;           // One-cycle strobes
        logic       wr;
    } ioCmd_t;

    // Idle request, also used while the MSX bus is in reset
    localparam msxReq_t REQ_IDLE = '{addr: 16'h0000, din: 8'h00, rd_n: 1'b1, wr_n: 1'b1,
                                     merq_n: 1'b1, iorq_n: 1'b1, sltsl_n: 1'b1, rfsh_n: 1'b1,
                                     m1_n: 1'b1, cs1_n: 1'b1, cs2_n: 1'b1, cs12_n: 1'b1,
                                     busReset_n: 1'b0};

    localparam msxResp_t RESP_IDLE = '{dout: 8'h00, busdir_n: 1'b1, int_n: 1'b1, wait_n: 1'b1};

endpackage

`default_nettype wire

/* logic/cartridge_macros.svh */
`ifndef CARTRIDGE_MACROS_SVH
`define CARTRIDGE_MACROS_SVH

// Secondary slots behind the primary slot
`define SLOT_COUNT 2

// 1 KiB SRAM, mirrored over page 4000h-7FFFh
`define SRAM_ADDR_BITS 10

// Scratch ports 40h-43h, timer reload 44h, status 45h
`define IO_BASE 8'h40

// CLK cycles per timer tick
`define TIMER_PRESCALE 16

`endif
